/* frontend_pkg.sv */
/*
 * Instruction fetch front end definitions.
 * Address and instruction types, major opcodes and the fetch FIFO entry.
 */
package frontend_pkg;

    // one fetch is always a single 32-bit word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // step between two sequential fetches, in bytes
    localparam int unsigned INSTR_BYTES = 4;

    // ------------------------------------------------------------------
    // RV32I major opcodes
    // ------------------------------------------------------------------
    // conditional branches (beq, bne, blt, bge, bltu, bgeu)
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    // unconditional jump and link
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

    // ------------------------------------------------------------------
    // entry handed to the back end through the fetch FIFO
    // ------------------------------------------------------------------
    typedef struct packed {
        // address the instruction was fetched from
        addr_t  address;
        // raw instruction word
        instr_t instr;
        // static prediction result
        logic   predict_taken;
        // next pc as predicted by the front end
        addr_t  predict_target;
    } fetch_entry_t;

endpackage

/* instr_scan.sv */
/*
 * Instruction scan.
 * Flags conditional branches and JAL and rebuilds their immediate.
 */
`timescale 1ns/1ps

module instr_scan import frontend_pkg::*; (
    input  instr_t instr_i,
    output logic   is_branch_o,
    output logic   is_jal_o,
    output addr_t  imm_o
);

    // immediates before sign extension, bit 0 is always zero
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    // major opcode match
    assign is_branch_o = (instr_i[6:0] == OPCODE_BRANCH);
    assign is_jal_o    = (instr_i[6:0] == OPCODE_JAL);

    // ------------------------------------------------------------------
    // immediate reassembly
    // ------------------------------------------------------------------
    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign b_imm = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    // J-type: imm[20|10:1|11|19:12] in 31:12
    assign j_imm = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // sign extend to address width, anything else reports zero
    always_comb begin
        if (is_jal_o) begin
            imm_o = addr_t'($signed(j_imm));
        end else if (is_branch_o) begin
            imm_o = addr_t'($signed(b_imm));
        end else begin
            imm_o = '0;
        end
    end

endmodule

/* pc_gen.sv */
/*
 * PC generation.
 * Holds the next pc and selects the fetch address by fixed priority.
 */
`timescale 1ns/1ps

module pc_gen import frontend_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  addr_t boot_addr_i,
    input  logic  if_ready_i,
    input  logic  bp_valid_i,
    input  addr_t bp_target_i,
    input  logic  mispredict_i,
    input  addr_t mispredict_target_i,
    input  logic  eret_i,
    input  addr_t epc_i,
    input  logic  ex_valid_i,
    input  addr_t trap_vector_base_i,
    input  logic  set_pc_commit_i,
    input  addr_t pc_commit_i,
    output addr_t fetch_addr_o
);

    addr_t npc_d, npc_q;
    // set for the first cycle out of reset, boot address is taken then
    logic  npc_rst_load_q;

    // ------------------------------------------------------------------
    // fetch address
    // ------------------------------------------------------------------
    always_comb begin
        if (bp_valid_i) begin
            fetch_addr_o = bp_target_i;
        end else if (npc_rst_load_q) begin
            fetch_addr_o = boot_addr_i;
        end else begin
            fetch_addr_o = npc_q;
        end
    end

    // ------------------------------------------------------------------
    // next pc, later assignments win
    // ------------------------------------------------------------------
    always_comb begin
        // hold whatever is being fetched now, keeps a taken prediction alive
        npc_d = fetch_addr_o;
        // sequential step once the cache took the request
        if (if_ready_i) begin
            npc_d = fetch_addr_o + addr_t'(INSTR_BYTES);
        end
        // branch resolved the other way in the back end
        if (mispredict_i) begin
            npc_d = mispredict_target_i;
        end
        // return from exception
        if (eret_i) begin
            npc_d = epc_i;
        end
        // exception or interrupt entry
        if (ex_valid_i) begin
            npc_d = trap_vector_base_i;
        end
        // pipeline restart behind the committing instruction
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + addr_t'(INSTR_BYTES);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q          <= '0;
            npc_rst_load_q <= 1'b1;
        end else begin
            npc_q          <= npc_d;
            npc_rst_load_q <= 1'b0;
        end
    end

    // no compressed support, every fetch lands on a word boundary
    a_fetch_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_ni) fetch_addr_o[1:0] == 2'b00);

endmodule

/* fetch_credit.sv */
/*
 * Fetch flow control.
 * One credit per free FIFO slot, drives the cache request and kills.
 */
`timescale 1ns/1ps

module fetch_credit #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic mispredict_i,
    input  logic bp_valid_i,
    input  logic icache_ready_i,
    input  logic icache_valid_i,
    input  logic pop_i,
    output logic icache_req_o,
    output logic icache_kill_s1_o,
    output logic icache_kill_s2_o,
    output logic if_ready_o
);

    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH) + 1;

    logic [CNT_W-1:0] credits_d, credits_q;
    logic             in_flight_d, in_flight_q;
    // accepted and not cancelled in stage 1
    logic             issue_req;
    // a request in flight is cancelled, its slot comes back
    logic             s2_eff_kill;

    // a redirect cancels the request presented now
    assign icache_kill_s1_o = mispredict_i | flush_i;
    // a taken prediction also drops the sequential request behind it
    assign icache_kill_s2_o = icache_kill_s1_o | bp_valid_i;

    // ------------------------------------------------------------------
    // request handshake
    // ------------------------------------------------------------------
    assign icache_req_o = (credits_q != '0);
    assign if_ready_o   = icache_ready_i & icache_req_o;
    assign issue_req    = if_ready_o & ~icache_kill_s1_o;
    assign s2_eff_kill  = in_flight_q & icache_kill_s2_o;

    // ------------------------------------------------------------------
    // credit counter and in-flight flag
    // ------------------------------------------------------------------
    assign credits_d = flush_i ? CNT_W'(FIFO_DEPTH) :
                       credits_q + CNT_W'(pop_i) + CNT_W'(s2_eff_kill) - CNT_W'(issue_req);

    // new request wins over the response or kill of the old one
    assign in_flight_d = flush_i                             ? 1'b0 :
                         issue_req                           ? 1'b1 :
                         (icache_valid_i | icache_kill_s2_o) ? 1'b0 :
                                                               in_flight_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credits_q   <= CNT_W'(FIFO_DEPTH);
            in_flight_q <= 1'b0;
        end else begin
            credits_q   <= credits_d;
            in_flight_q <= in_flight_d;
        end
    end

    a_credit_max : assert property (
        @(posedge clk_i) disable iff (!rst_ni) credits_q <= CNT_W'(FIFO_DEPTH));

endmodule

/* fetch_predict.sv */
/*
 * Fetch response stage.
 * Registers the cache response, predicts statically and builds the entry.
 */
`timescale 1ns/1ps

module fetch_predict import frontend_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         icache_valid_i,
    input  instr_t       icache_data_i,
    input  addr_t        icache_rvaddr_i,
    input  logic         kill_s2_i,
    output logic         push_o,
    output fetch_entry_t entry_o,
    output logic         bp_valid_o,
    output addr_t        bp_target_o
);

    logic   valid_q;
    instr_t data_q;
    addr_t  vaddr_q;
    // scan results of the registered word
    logic   is_branch, is_jal;
    addr_t  imm;
    logic   taken;

    // ------------------------------------------------------------------
    // response register
    // ------------------------------------------------------------------
    // a response arriving together with a kill is dropped
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= icache_valid_i & ~kill_s2_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_q  <= icache_data_i;
        vaddr_q <= icache_rvaddr_i;
    end

    instr_scan i_instr_scan (
        .instr_i     (data_q),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .imm_o       (imm)
    );

    // ------------------------------------------------------------------
    // static prediction
    // ------------------------------------------------------------------
    // backward branches are loops, jal always jumps
    assign taken       = is_jal | (is_branch & imm[$bits(addr_t)-1]);
    assign bp_valid_o  = valid_q & taken;
    // not taken falls through to the next word
    assign bp_target_o = taken ? (vaddr_q + imm) : (vaddr_q + addr_t'(INSTR_BYTES));

    assign push_o                 = valid_q;
    assign entry_o.address        = vaddr_q;
    assign entry_o.instr          = data_q;
    assign entry_o.predict_taken  = taken;
    assign entry_o.predict_target = bp_target_o;

endmodule

/* fetch_fifo.sv */
/*
 * Fetch FIFO.
 * Circular buffer of any payload type, emptied by flush in one edge.
 */
`timescale 1ns/1ps

module fetch_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type         dtype = logic
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic push_i,
    input  dtype data_i,
    input  logic pop_i,
    output dtype data_o,
    output logic empty_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // payload storage
    dtype             mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;

    assign empty_o = (count_q == '0);
    assign full    = (count_q == CNT_W'(DEPTH));
    // head entry, only meaningful while not empty
    assign data_o  = mem_q[rd_ptr_q];

    // ------------------------------------------------------------------
    // pointers and fill count
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // wrap explicitly so depths that are no power of two work
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // upstream flow control keeps both of these from happening
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!rst_ni || flush_i) push_i |-> !full);
    a_no_underflow : assert property (
        @(posedge clk_i) disable iff (!rst_ni || flush_i) pop_i |-> !empty_o);

endmodule

/* frontend.sv */
/*
 * Instruction fetch front end.
 * Next pc selection, credit based cache requests, static prediction, fetch FIFO.
 */
`timescale 1ns/1ps

module frontend import frontend_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  addr_t        boot_addr_i,
    // redirects from the back end
    input  logic         mispredict_i,
    input  addr_t        mispredict_target_i,
    input  logic         eret_i,
    input  addr_t        epc_i,
    input  logic         ex_valid_i,
    input  addr_t        trap_vector_base_i,
    input  logic         set_pc_commit_i,
    input  addr_t        pc_commit_i,
    // instruction cache
    output logic         icache_req_o,
    output addr_t        icache_vaddr_o,
    output logic         icache_kill_s1_o,
    output logic         icache_kill_s2_o,
    input  logic         icache_ready_i,
    input  logic         icache_valid_i,
    input  instr_t       icache_data_i,
    input  addr_t        icache_rvaddr_i,
    // towards decode
    output fetch_entry_t fetch_entry_o,
    output logic         fetch_valid_o,
    input  logic         fetch_ack_i
);

    logic         if_ready;
    logic         bp_valid;
    addr_t        bp_target;
    logic         fifo_push;
    logic         fifo_pop;
    logic         fifo_empty;
    fetch_entry_t fifo_entry;

    // ------------------------------------------------------------------
    // handshake towards decode
    // ------------------------------------------------------------------
    assign fetch_valid_o = ~fifo_empty;
    assign fifo_pop      = fetch_ack_i & fetch_valid_o;

    pc_gen i_pc_gen (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .boot_addr_i         (boot_addr_i),
        .if_ready_i          (if_ready),
        .bp_valid_i          (bp_valid),
        .bp_target_i         (bp_target),
        .mispredict_i        (mispredict_i),
        .mispredict_target_i (mispredict_target_i),
        .eret_i              (eret_i),
        .epc_i               (epc_i),
        .ex_valid_i          (ex_valid_i),
        .trap_vector_base_i  (trap_vector_base_i),
        .set_pc_commit_i     (set_pc_commit_i),
        .pc_commit_i         (pc_commit_i),
        .fetch_addr_o        (icache_vaddr_o)
    );

    fetch_credit #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fetch_credit (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .mispredict_i     (mispredict_i),
        .bp_valid_i       (bp_valid),
        .icache_ready_i   (icache_ready_i),
        .icache_valid_i   (icache_valid_i),
        .pop_i            (fifo_pop),
        .icache_req_o     (icache_req_o),
        .icache_kill_s1_o (icache_kill_s1_o),
        .icache_kill_s2_o (icache_kill_s2_o),
        .if_ready_o       (if_ready)
    );

    fetch_predict i_fetch_predict (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .icache_valid_i  (icache_valid_i),
        .icache_data_i   (icache_data_i),
        .icache_rvaddr_i (icache_rvaddr_i),
        .kill_s2_i       (icache_kill_s2_o),
        .push_o          (fifo_push),
        .entry_o         (fifo_entry),
        .bp_valid_o      (bp_valid),
        .bp_target_o     (bp_target)
    );

    // credits guarantee a free slot for every push
    fetch_fifo #(
        .DEPTH (FIFO_DEPTH),
        .dtype (fetch_entry_t)
    ) i_fetch_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .push_i  (fifo_push),
        .data_i  (fifo_entry),
        .pop_i   (fifo_pop),
        .data_o  (fetch_entry_o),
        .empty_o (fifo_empty)
    );

endmodule

/* tb_frontend.sv */
/*
 * Testbench for the instruction fetch front end.
 * Cache model, reference address stream and directed tests.
 */
`timescale 1ns/1ps

module tb_frontend import frontend_pkg::*; ();

    localparam int unsigned FIFO_DEPTH = 4;

    // ------------------------------------------------------------------
    // address map of the test program
    // ------------------------------------------------------------------
    localparam addr_t BOOT_ADDR   = 32'h0000_0100;
    localparam addr_t LOOP_ENTRY  = 32'h0000_1000;
    localparam addr_t MP_TARGET   = 32'h0000_2000;
    localparam addr_t EPC_ADDR    = 32'h0000_3000;
    localparam addr_t TRAP_BASE   = 32'h0000_4000;
    localparam addr_t PC_COMMIT   = 32'h0000_5000;
    // forward branch that falls through
    localparam addr_t FWD_BR_ADDR = 32'h0000_1008;
    localparam addr_t FWD_BR_OFF  = 32'h0000_0010;
    // jal into the loop body
    localparam addr_t JAL_ADDR    = 32'h0000_1010;
    localparam addr_t JAL_OFF     = 32'h0000_0020;
    // loop closing branch jumps -0x34 back to the forward branch
    localparam addr_t BWD_BR_ADDR = 32'h0000_103C;
    localparam addr_t BWD_BR_OFF  = 32'hFFFF_FFCC;

    // tests take about 400 cycles including random ready stalls
    localparam int unsigned TEST_CYCLES    = 400;
    // watchdog margin of five times the test length
    localparam int unsigned TIMEOUT_CYCLES = 5 * TEST_CYCLES;
    localparam int unsigned WAIT_LIMIT     = 300;

    logic         clk_i;
    logic         rst_ni;
    logic         flush_i;
    addr_t        boot_addr_i;
    logic         mispredict_i;
    addr_t        mispredict_target_i;
    logic         eret_i;
    addr_t        epc_i;
    logic         ex_valid_i;
    addr_t        trap_vector_base_i;
    logic         set_pc_commit_i;
    addr_t        pc_commit_i;
    logic         icache_req_o;
    addr_t        icache_vaddr_o;
    logic         icache_kill_s1_o;
    logic         icache_kill_s2_o;
    logic         icache_ready_i;
    logic         icache_valid_i;
    instr_t       icache_data_i;
    addr_t        icache_rvaddr_i;
    fetch_entry_t fetch_entry_o;
    logic         fetch_valid_o;
    logic         fetch_ack_i;

    // reference state
    addr_t exp_addr;
    int    pop_cnt;
    int    outstanding;
    // cache drops ready at random when set
    logic  rand_ready;

    frontend #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) frontend_i (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .boot_addr_i         (boot_addr_i),
        .mispredict_i        (mispredict_i),
        .mispredict_target_i (mispredict_target_i),
        .eret_i              (eret_i),
        .epc_i               (epc_i),
        .ex_valid_i          (ex_valid_i),
        .trap_vector_base_i  (trap_vector_base_i),
        .set_pc_commit_i     (set_pc_commit_i),
        .pc_commit_i         (pc_commit_i),
        .icache_req_o        (icache_req_o),
        .icache_vaddr_o      (icache_vaddr_o),
        .icache_kill_s1_o    (icache_kill_s1_o),
        .icache_kill_s2_o    (icache_kill_s2_o),
        .icache_ready_i      (icache_ready_i),
        .icache_valid_i      (icache_valid_i),
        .icache_data_i       (icache_data_i),
        .icache_rvaddr_i     (icache_rvaddr_i),
        .fetch_entry_o       (fetch_entry_o),
        .fetch_valid_o       (fetch_valid_o),
        .fetch_ack_i         (fetch_ack_i)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // ------------------------------------------------------------------
    // program memory built from RV32I encodings
    // ------------------------------------------------------------------
    function automatic instr_t enc_branch(input addr_t off);
        // beq x1, x2 with a B-type immediate
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPCODE_BRANCH};
    endfunction

    function automatic instr_t enc_jal(input addr_t off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPCODE_JAL};
    endfunction

    // 0 plain, 1 conditional branch, 2 jal
    function automatic int ctrl_kind(input addr_t a);
        case (a)
            FWD_BR_ADDR, BWD_BR_ADDR: return 1;
            JAL_ADDR:                 return 2;
            default:                  return 0;
        endcase
    endfunction

    function automatic addr_t ctrl_offset(input addr_t a);
        case (a)
            FWD_BR_ADDR: return FWD_BR_OFF;
            BWD_BR_ADDR: return BWD_BR_OFF;
            JAL_ADDR:    return JAL_OFF;
            default:     return '0;
        endcase
    endfunction

    function automatic instr_t mem_word(input addr_t a);
        case (ctrl_kind(a))
            1:       return enc_branch(ctrl_offset(a));
            2:       return enc_jal(ctrl_offset(a));
            // addi-type filler that differs for every word address
            default: return {a[31:7] ^ {a[6:2], 20'h5a5a5}, 7'b0010011};
        endcase
    endfunction

    // ------------------------------------------------------------------
    // cache model with one cycle latency
    // ------------------------------------------------------------------
    initial begin : cache_model
        logic  pend;
        addr_t pend_addr;
        forever begin
            // handshake is stable in the middle of the cycle
            @(negedge clk_i);
            pend      = rst_ni && icache_req_o && icache_ready_i && !icache_kill_s1_o;
            pend_addr = icache_vaddr_o;
            @(posedge clk_i);
            #1;
            // a kill_s2 in this cycle makes the DUT drop the word
            icache_valid_i  = pend;
            icache_data_i   = pend ? mem_word(pend_addr) : '0;
            icache_rvaddr_i = pend_addr;
            icache_ready_i  = rand_ready ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // reference stream and credit bookkeeping
    // ------------------------------------------------------------------
    task automatic check_entry(input fetch_entry_t e);
        int    kind;
        addr_t off;
        addr_t exp_target;
        logic  exp_taken;
        kind = ctrl_kind(exp_addr);
        off  = ctrl_offset(exp_addr);
        // jal is always taken and a branch only when it points backwards
        exp_taken  = (kind == 2) || (kind == 1 && off[31]);
        exp_target = exp_taken ? exp_addr + off : exp_addr + addr_t'(INSTR_BYTES);
        assert (e.address == exp_addr) else fail_run($sformatf(
            "MISMATCH %0t: entry address %h, expected %h", $time, e.address, exp_addr));
        assert (e.instr == mem_word(exp_addr)) else fail_run($sformatf(
            "MISMATCH %0t: instr %h at %h", $time, e.instr, exp_addr));
        assert (e.predict_taken == exp_taken) else fail_run($sformatf(
            "MISMATCH %0t: predict_taken %b at %h", $time, e.predict_taken, exp_addr));
        assert (e.predict_target == exp_target) else fail_run($sformatf(
            "MISMATCH %0t: target %h, expected %h", $time, e.predict_target, exp_target));
        exp_addr = exp_target;
    endtask

    always @(negedge clk_i) begin
        if (rst_ni && flush_i) begin
            outstanding = 0;
        end else if (rst_ni) begin
            // words owned by the front end in the cache pipe and the FIFO
            if (icache_req_o && icache_ready_i && !icache_kill_s1_o) begin
                outstanding++;
            end
            if (icache_valid_i && icache_kill_s2_o) begin
                outstanding--;
            end
            if (fetch_valid_o && fetch_ack_i) begin
                check_entry(fetch_entry_o);
                outstanding--;
                pop_cnt++;
            end
            assert (outstanding <= int'(FIFO_DEPTH)) else fail_run($sformatf(
                "MISMATCH %0t: %0d words accepted beyond the FIFO", $time, outstanding));
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the DUT stopped delivering", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

    // ------------------------------------------------------------------
    // helpers called at posedge plus 1 ns
    // ------------------------------------------------------------------
    task automatic wait_pops(input int n);
        int target;
        int guard;
        target      = pop_cnt + n;
        guard       = 0;
        fetch_ack_i = 1'b1;
        while (pop_cnt < target && guard < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            guard++;
        end
        assert (pop_cnt >= target) else fail_run("no fetch entry arrived within the wait limit");
    endtask

    // one cycle pulse of the chosen redirects together with flush
    task automatic redirect(input logic mp, input logic er, input logic ex, input logic cm,
                            input addr_t expected);
        fetch_ack_i     = 1'b0;
        flush_i         = 1'b1;
        mispredict_i    = mp;
        eret_i          = er;
        ex_valid_i      = ex;
        set_pc_commit_i = cm;
        exp_addr        = expected;
        @(posedge clk_i);
        #1;
        flush_i         = 1'b0;
        mispredict_i    = 1'b0;
        eret_i          = 1'b0;
        ex_valid_i      = 1'b0;
        set_pc_commit_i = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic check_reset_state();
        @(negedge clk_i);
        assert (!fetch_valid_o && !icache_kill_s1_o && !icache_kill_s2_o)
            else fail_run("valid or kill outputs high right after reset");
        assert (icache_req_o) else fail_run("no cache request with full credits after reset");
        assert (icache_vaddr_o == BOOT_ADDR) else fail_run($sformatf(
            "MISMATCH %0t: first fetch address %h", $time, icache_vaddr_o));
        @(posedge clk_i);
        #1;
    endtask

    task automatic test_boot_fetch();
        rand_ready = 1'b0;
        wait_pops(8);
    endtask

    task automatic test_backpressure();
        int guard;
        rand_ready  = 1'b1;
        fetch_ack_i = 1'b0;
        guard       = 0;
        // credits run out once FIFO_DEPTH words are owned
        while (icache_req_o && guard < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            guard++;
        end
        assert (!icache_req_o) else fail_run("cache requests continue under back-pressure");
        repeat (10) @(posedge clk_i);
        #1;
        assert (!icache_req_o && outstanding == int'(FIFO_DEPTH)) else fail_run($sformatf(
            "MISMATCH %0t: %0d words held under back-pressure", $time, outstanding));
        // order and completeness come from the reference stream
        wait_pops(12);
    endtask

    task automatic test_prediction();
        mispredict_target_i = LOOP_ENTRY;
        redirect(1'b1, 1'b0, 1'b0, 1'b0, LOOP_ENTRY);
        // about three trips through the forward branch, the jal and the backward branch
        wait_pops(24);
        mispredict_target_i = MP_TARGET;
    endtask

    task automatic test_redirects();
        redirect(1'b1, 1'b0, 1'b0, 1'b0, MP_TARGET);
        wait_pops(3);
        redirect(1'b0, 1'b1, 1'b0, 1'b0, EPC_ADDR);
        wait_pops(3);
        redirect(1'b0, 1'b0, 1'b1, 1'b0, TRAP_BASE);
        wait_pops(3);
        // restart after the committing instruction
        redirect(1'b0, 1'b0, 1'b0, 1'b1, PC_COMMIT + addr_t'(INSTR_BYTES));
        wait_pops(3);
    endtask

    task automatic test_priority();
        redirect(1'b1, 1'b1, 1'b1, 1'b1, PC_COMMIT + addr_t'(INSTR_BYTES));
        wait_pops(3);
        redirect(1'b1, 1'b1, 1'b1, 1'b0, TRAP_BASE);
        wait_pops(3);
        redirect(1'b1, 1'b1, 1'b0, 1'b0, EPC_ADDR);
        wait_pops(3);
    endtask

    initial begin : main_seq
        void'($urandom(56375));
        rst_ni              = 1'b0;
        flush_i             = 1'b0;
        boot_addr_i         = BOOT_ADDR;
        mispredict_i        = 1'b0;
        mispredict_target_i = MP_TARGET;
        eret_i              = 1'b0;
        epc_i               = EPC_ADDR;
        ex_valid_i          = 1'b0;
        trap_vector_base_i  = TRAP_BASE;
        set_pc_commit_i     = 1'b0;
        pc_commit_i         = PC_COMMIT;
        icache_ready_i      = 1'b1;
        icache_valid_i      = 1'b0;
        icache_data_i       = '0;
        icache_rvaddr_i     = '0;
        fetch_ack_i         = 1'b0;
        rand_ready          = 1'b0;
        exp_addr            = BOOT_ADDR;
        pop_cnt             = 0;
        outstanding         = 0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_reset_state();
        test_boot_fetch();
        test_backpressure();
        test_prediction();
        test_redirects();
        test_priority();
        repeat (4) @(posedge clk_i);
        $display("Test OK");
        $finish;
    end

endmodule

/* files.f */
frontend_pkg.sv
instr_scan.sv
pc_gen.sv
fetch_credit.sv
fetch_predict.sv
fetch_fifo.sv
frontend.sv
tb_frontend.sv

/* run.sh */
#!/usr/bin/env bash
# build the fetch front end testbench with Verilator and run it
# exit status is zero only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend \
    -f files.f -o tb_frontend_sim \
    && ./obj_dir/tb_frontend_sim | tee /dev/stderr | grep -qx "Test OK" \
    && exit 0 || exit 1
